// File: uart_cfg_pkg.sv
package uart_cfg_pkg;

  // --------------------
  // Oversample timing
  // --------------------
  localparam int unsigned OVERSAMPLE = 16;               // Ticks per bit
  localparam int unsigned POS_W      = 5;                // Position counter width

  localparam logic [POS_W-1:0] POS_LAST     = POS_W'(OVERSAMPLE - 1);  // Wrap point
  localparam logic [POS_W-1:0] BIT_CENTER   = POS_W'(8);  // Bit decided here
  localparam logic [POS_W-1:0] MAJ_START    = POS_W'(5);  // Vote cleared, samples at 6..8
  localparam logic [POS_W-1:0] START_OFFSET = POS_W'(2);  // Start edge caught on a tick

  // Character timeout, four worst case frames
  localparam int unsigned FRAME_BITS    = 12;            // Start, 8 data, parity, 2 stop
  localparam int unsigned TIMEOUT_TICKS = 4 * FRAME_BITS * OVERSAMPLE;
  localparam int unsigned TO_W          = $clog2(TIMEOUT_TICKS);
  localparam logic [TO_W-1:0] TO_LAST   = TO_W'(TIMEOUT_TICKS - 1);

  // --------------------
  // Line control
  // --------------------
  typedef enum logic [1:0] {
    WLEN_5, WLEN_6, WLEN_7, WLEN_8
  } word_len_e;

  // Same order as the LCR parity field
  typedef enum logic [1:0] {
    PAR_ODD, PAR_EVEN, PAR_ONE, PAR_ZERO
  } par_mode_e;

  // FIFO trigger, in characters held
  typedef enum logic [1:0] {
    TRIG_1, TRIG_4, TRIG_8, TRIG_14
  } trig_lvl_e;

endpackage

// File: uart_rx_pkg.sv
package uart_rx_pkg;

  // Receiver FSM
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PAR,
    RX_STOP,
    RX_RESYNC    // Wait for marking line after framing error
  } rx_state_e;

  // One FIFO word, 11 bits
  typedef struct packed {
    logic       par_err;
    logic       frame_err;
    logic       brk;
    logic [7:0] char;
  } rx_entry_t;

  // --------------------
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W      = 5;                      // Holds 0..FIFO_DEPTH
  localparam logic [CNT_W-1:0] CREDIT_INIT = CNT_W'(FIFO_DEPTH);  // All slots free

endpackage

// File: uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler import uart_cfg_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic oversample_tick_i,
  input  logic rxd_i,
  input  logic pos_clear_i,   // Hold position at zero
  input  logic pos_load_i,    // Load START_OFFSET
  output logic rxd_sync_o,
  output logic bit_center_o,  // One clk_i pulse per bit
  output logic bit_val_o      // Majority vote, valid with bit_center_o
);

  logic [1:0]       sync_q;     // Two stage synchronizer
  logic [POS_W-1:0] pos_q;      // Oversample position in bit
  logic             center_q;
  logic             at_center;
  logic [1:0]       maj_cnt_q;  // Ones seen at 6 and 7
  logic [1:0]       votes;

  // --------------------
  // Input synchronizer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b11;  // Line idles high
    end else begin
      sync_q <= {sync_q[0], rxd_i};
    end
  end

  assign rxd_sync_o = sync_q[1];

  // Position counter
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pos_q <= '0;
    end else if (pos_load_i) begin
      pos_q <= START_OFFSET;
    end else if (pos_clear_i) begin
      pos_q <= '0;
    end else if (oversample_tick_i) begin
      pos_q <= (pos_q == POS_LAST) ? '0 : pos_q + POS_W'(1);  // Wrap at 15
    end
  end

  // --------------------
  // Bit center and vote
  // --------------------
  assign at_center = (pos_q == BIT_CENTER);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      center_q  <= 1'b0;
      maj_cnt_q <= '0;
    end else begin
      center_q <= at_center;
      if (oversample_tick_i) begin
        if (pos_q == MAJ_START) begin
          maj_cnt_q <= '0;                       // Fresh vote each bit
        end else if (pos_q > MAJ_START && pos_q < BIT_CENTER && rxd_sync_o) begin
          maj_cnt_q <= maj_cnt_q + 2'd1;
        end
      end
    end
  end

  assign votes        = maj_cnt_q + {1'b0, rxd_sync_o};  // Third sample taken live at 8
  assign bit_val_o    = votes[1];                        // Two of three high
  assign bit_center_o = at_center & ~center_q;           // Rising edge only

endmodule

// File: uart_rx_deframer.sv
`timescale 1ns/1ps

module uart_rx_deframer import uart_cfg_pkg::*, uart_rx_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      oversample_tick_i,
  input  logic      rxd_sync_i,
  input  logic      bit_center_i,
  input  logic      bit_val_i,
  input  word_len_e word_len_i,
  input  logic      par_en_i,
  input  par_mode_e par_mode_i,
  input  logic      credit_ret_i,    // One slot freed in FIFO
  output logic      pos_clear_o,
  output logic      pos_load_o,
  output logic      push_o,
  output rx_entry_t push_entry_o,
  output logic      overrun_o        // Character dropped, no credit
);

  rx_state_e        state_q, state_d;
  logic [7:0]       rsr_q, rsr_d;          // Receive shift register
  logic [2:0]       bit_cnt_q, bit_cnt_d;
  logic [2:0]       last_idx;              // Index of last data bit
  logic             par_err_q, par_err_d;
  logic             par_one_q, par_one_d;  // Parity bit was high
  logic             stop_done;
  logic             frame_err;
  logic             brk;
  logic             spend;
  logic [CNT_W-1:0] credit_q;
  logic             push_q, overrun_q;
  rx_entry_t        entry_q;

  always_comb begin
    case (word_len_i)
      WLEN_5:  last_idx = 3'd4;
      WLEN_6:  last_idx = 3'd5;
      WLEN_7:  last_idx = 3'd6;
      default: last_idx = 3'd7;
    endcase
  end

  // --------------------
  // Receive FSM
  // --------------------
  always_comb begin
    state_d     = state_q;
    rsr_d       = rsr_q;
    bit_cnt_d   = bit_cnt_q;
    par_err_d   = par_err_q;
    par_one_d   = par_one_q;
    pos_clear_o = 1'b0;
    pos_load_o  = 1'b0;
    stop_done   = 1'b0;
    frame_err   = 1'b0;
    case (state_q)
      RX_IDLE: begin
        pos_clear_o = 1'b1;              // Counter parked at zero
        if (!rxd_sync_i) begin
          state_d = RX_START;
          if (oversample_tick_i) begin   // Edge already one tick old
            pos_load_o  = 1'b1;
            pos_clear_o = 1'b0;
          end
        end
      end
      RX_START: begin
        if (bit_center_i) begin
          if (!bit_val_i) begin
            state_d   = RX_DATA;
            rsr_d     = '0;              // Upper bits stay zero for short words
            bit_cnt_d = '0;
            par_err_d = 1'b0;
            par_one_d = 1'b0;
          end else begin
            state_d = RX_IDLE;           // Glitch, not a start bit
          end
        end
      end
      RX_DATA: begin
        if (bit_center_i) begin
          rsr_d[bit_cnt_q] = bit_val_i;  // LSB first
          bit_cnt_d        = bit_cnt_q + 3'd1;
          if (bit_cnt_q == last_idx) begin
            state_d = par_en_i ? RX_PAR : RX_STOP;
          end
        end
      end
      RX_PAR: begin
        if (bit_center_i) begin
          case (par_mode_i)
            PAR_ODD:  par_err_d = (bit_val_i == ^rsr_q);
            PAR_EVEN: par_err_d = (bit_val_i != ^rsr_q);
            PAR_ONE:  par_err_d = ~bit_val_i;
            default:  par_err_d = bit_val_i;     // Forced 0
          endcase
          par_one_d = bit_val_i;
          state_d   = RX_STOP;
        end
      end
      RX_STOP: begin
        if (bit_center_i) begin
          stop_done = 1'b1;
          frame_err = ~bit_val_i;
          state_d   = bit_val_i ? RX_IDLE : RX_RESYNC;
        end
      end
      RX_RESYNC: begin
        pos_clear_o = 1'b1;
        if (rxd_sync_i) begin
          state_d = RX_IDLE;            // Line back to marking
        end
      end
      default: state_d = RX_IDLE;
    endcase
  end

  // Break: data, parity and stop all low
  assign brk   = ~|rsr_q & ~par_one_q & ~bit_val_i;
  assign spend = stop_done & (credit_q != '0);

  // --------------------
  // Registers and credits
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
      par_err_q <= 1'b0;
      par_one_q <= 1'b0;
      credit_q  <= CREDIT_INIT;     // FIFO starts empty
      push_q    <= 1'b0;
      overrun_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      bit_cnt_q <= bit_cnt_d;
      par_err_q <= par_err_d;
      par_one_q <= par_one_d;
      push_q    <= spend;
      overrun_q <= stop_done & ~spend;
      case ({credit_ret_i, spend})
        2'b10:   credit_q <= credit_q + CNT_W'(1);
        2'b01:   credit_q <= credit_q - CNT_W'(1);
        default: credit_q <= credit_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    rsr_q <= rsr_d;
    if (stop_done) begin
      entry_q <= '{par_err: par_err_q, frame_err: frame_err, brk: brk, char: rsr_q};
    end
  end

  assign push_o       = push_q;
  assign push_entry_o = entry_q;
  assign overrun_o    = overrun_q;

endmodule

// File: uart_rx_fifo.sv
`timescale 1ns/1ps

module uart_rx_fifo import uart_rx_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,        // Producer holds a credit
  input  rx_entry_t        push_entry_i,
  input  logic             pop_i,
  output rx_entry_t        pop_entry_o,   // Head of queue
  output logic             empty_o,
  output logic [CNT_W-1:0] usage_o,
  output logic             credit_ret_o   // One pulse per pop
);

  rx_entry_t        mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;  // Wrap naturally at 16
  logic [CNT_W-1:0] usage_q;
  logic             do_pop;

  assign empty_o = (usage_q == '0);
  assign do_pop  = pop_i & ~empty_o;    // Ignore pop on empty

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (do_pop) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      case ({push_i, do_pop})
        2'b10:   usage_q <= usage_q + CNT_W'(1);
        2'b01:   usage_q <= usage_q - CNT_W'(1);
        default: usage_q <= usage_q;
      endcase
    end
  end

  assign pop_entry_o  = mem_q[rd_ptr_q];  // Visible the cycle after push
  assign usage_o      = usage_q;
  assign credit_ret_o = do_pop;           // Slot freed back to deframer

endmodule

// File: uart_rx_holding.sv
`timescale 1ns/1ps

module uart_rx_holding import uart_cfg_pkg::*, uart_rx_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             oversample_tick_i,
  input  rx_entry_t        pop_entry_i,
  input  logic             empty_i,
  input  logic [CNT_W-1:0] usage_i,
  input  logic             overrun_i,      // Pulse from deframer
  input  logic             rhr_rd_i,       // Host takes character
  input  logic             lsr_rd_i,       // Host reads and clears status
  input  trig_lvl_e        trig_lvl_i,
  output logic             pop_o,
  output logic [7:0]       rhr_o,
  output logic             data_ready_o,
  output logic             overrun_err_o,
  output logic             par_err_o,
  output logic             frame_err_o,
  output logic             break_o,
  output logic             trigger_o,
  output logic             timeout_o
);

  logic             full_q;                 // RHR holds a character
  logic [7:0]       rhr_q;
  logic             par_err_q, frame_err_q, brk_q, overrun_q;
  logic [CNT_W-1:0] held, trig_cnt;
  logic             waiting;
  logic [TO_W-1:0]  to_cnt_q;
  logic             to_fired_q, timeout_q;

  assign pop_o = ~full_q & ~empty_i;        // Refill as soon as RHR is free

  // --------------------
  // RHR and line status
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q      <= 1'b0;
      par_err_q   <= 1'b0;
      frame_err_q <= 1'b0;
      brk_q       <= 1'b0;
      overrun_q   <= 1'b0;
    end else begin
      if (pop_o)         full_q <= 1'b1;
      else if (rhr_rd_i) full_q <= 1'b0;
      // Sticky, a new error wins over a clear
      par_err_q   <= (par_err_q & ~lsr_rd_i) | (pop_o & pop_entry_i.par_err);
      frame_err_q <= (frame_err_q & ~lsr_rd_i) | (pop_o & pop_entry_i.frame_err);
      brk_q       <= (brk_q & ~lsr_rd_i) | (pop_o & pop_entry_i.brk);
      overrun_q   <= (overrun_q & ~lsr_rd_i) | overrun_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) rhr_q <= pop_entry_i.char;
  end

  // Trigger on characters in FIFO plus RHR
  always_comb begin
    case (trig_lvl_i)
      TRIG_1:  trig_cnt = CNT_W'(1);
      TRIG_4:  trig_cnt = CNT_W'(4);
      TRIG_8:  trig_cnt = CNT_W'(8);
      default: trig_cnt = CNT_W'(14);
    endcase
  end

  assign held    = usage_i + CNT_W'(full_q);
  assign waiting = full_q | ~empty_i;

  // --------------------
  // Character timeout
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      to_cnt_q   <= '0;
      to_fired_q <= 1'b0;
      timeout_q  <= 1'b0;
    end else begin
      timeout_q <= 1'b0;
      if (!waiting || rhr_rd_i || pop_o) begin  // Activity restarts the wait
        to_cnt_q   <= '0;
        to_fired_q <= 1'b0;
      end else if (oversample_tick_i && !to_fired_q) begin
        if (to_cnt_q == TO_LAST) begin
          timeout_q  <= 1'b1;                   // Once per idle period
          to_fired_q <= 1'b1;
        end else begin
          to_cnt_q <= to_cnt_q + TO_W'(1);
        end
      end
    end
  end

  assign rhr_o         = rhr_q;
  assign data_ready_o  = full_q;
  assign overrun_err_o = overrun_q;
  assign par_err_o     = par_err_q;
  assign frame_err_o   = frame_err_q;
  assign break_o       = brk_q;
  assign trigger_o     = (held >= trig_cnt);
  assign timeout_o     = timeout_q;

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_cfg_pkg::*, uart_rx_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       oversample_tick_i,  // 16x baud enable
  input  logic       rxd_i,
  input  word_len_e  word_len_i,
  input  logic       par_en_i,
  input  par_mode_e  par_mode_i,
  input  trig_lvl_e  trig_lvl_i,
  input  logic       rhr_rd_i,
  input  logic       lsr_rd_i,
  output logic [7:0] rhr_o,
  output logic       data_ready_o,
  output logic       overrun_err_o,
  output logic       par_err_o,
  output logic       frame_err_o,
  output logic       break_o,
  output logic       trigger_o,
  output logic       timeout_o
);

  logic             rxd_sync, bit_center, bit_val;  // Sampler to deframer
  logic             pos_clear, pos_load;
  logic             push, overrun, credit_ret;      // Deframer and FIFO
  rx_entry_t        push_entry, pop_entry;
  logic             empty, pop;                     // FIFO and RHR
  logic [CNT_W-1:0] usage;

  // --------------------
  // Producer
  // --------------------
  uart_rx_sampler i_sampler (
    .clk_i, .rst_n_i, .oversample_tick_i, .rxd_i,
    .pos_clear_i (pos_clear),
    .pos_load_i  (pos_load),
    .rxd_sync_o  (rxd_sync),
    .bit_center_o(bit_center),
    .bit_val_o   (bit_val)
  );

  uart_rx_deframer i_deframer (
    .clk_i, .rst_n_i, .oversample_tick_i, .word_len_i, .par_en_i, .par_mode_i,
    .rxd_sync_i  (rxd_sync),
    .bit_center_i(bit_center),
    .bit_val_i   (bit_val),
    .credit_ret_i(credit_ret),
    .pos_clear_o (pos_clear),
    .pos_load_o  (pos_load),
    .push_o      (push),
    .push_entry_o(push_entry),
    .overrun_o   (overrun)
  );

  // Buffer
  uart_rx_fifo i_fifo (
    .clk_i, .rst_n_i,
    .push_i      (push),
    .push_entry_i(push_entry),
    .pop_i       (pop),
    .pop_entry_o (pop_entry),
    .empty_o     (empty),
    .usage_o     (usage),
    .credit_ret_o(credit_ret)
  );

  // Consumer, host side
  uart_rx_holding i_holding (
    .clk_i, .rst_n_i, .oversample_tick_i, .rhr_rd_i, .lsr_rd_i, .trig_lvl_i,
    .pop_entry_i(pop_entry),
    .empty_i    (empty),
    .usage_i    (usage),
    .overrun_i  (overrun),
    .pop_o      (pop),
    .rhr_o, .data_ready_o, .overrun_err_o, .par_err_o, .frame_err_o,
    .break_o, .trigger_o, .timeout_o
  );

endmodule

// File: tb_uart_rx.sv
`timescale 1ns/1ps

module tb_uart_rx import uart_cfg_pkg::*; ();

  localparam int FRAME_CYC = 12 * OVERSAMPLE;        // Longest frame plus idle gap
  localparam int READY_MAX = 4 * FRAME_CYC;

  logic       clk, rst_n, tick, rxd;
  word_len_e  word_len;
  logic       par_en;
  par_mode_e  par_mode;
  trig_lvl_e  trig_lvl;
  logic       rhr_rd, lsr_rd;
  logic [7:0] rhr;
  logic       data_ready, overrun_err, par_err, frame_err, brk, trigger, timeout;

  integer     seed;
  int         errors, checks, tests, errs_before;
  logic [7:0] exp_chars [18];                        // Overrun burst in send order

  initial clk = 1'b0;
  always #50 clk = ~clk;                             // 100 ns period

  uart_rx dut_i (
    .clk_i(clk), .rst_n_i(rst_n), .oversample_tick_i(tick), .rxd_i(rxd),
    .word_len_i(word_len), .par_en_i(par_en), .par_mode_i(par_mode),
    .trig_lvl_i(trig_lvl), .rhr_rd_i(rhr_rd), .lsr_rd_i(lsr_rd),
    .rhr_o(rhr), .data_ready_o(data_ready), .overrun_err_o(overrun_err),
    .par_err_o(par_err), .frame_err_o(frame_err), .break_o(brk),
    .trigger_o(trigger), .timeout_o(timeout)
  );

  // --------------------
  // Serial line driver
  // --------------------
  task automatic send_bit(input logic b);
    @(posedge clk);
    rxd <= b;
    repeat (OVERSAMPLE - 1) @(posedge clk);          // 16 clocks per bit
  endtask

  task automatic send_frame(input logic [7:0] data, input int nbits, input logic with_par,
                            input logic pbit, input logic stop);
    send_bit(1'b0);                                  // Start
    for (int i = 0; i < nbits; i++) send_bit(data[i]);  // LSB first
    if (with_par) send_bit(pbit);
    send_bit(stop);
    send_bit(1'b1);                                  // Marking gap
  endtask

  // Expected parity bit for a correct frame
  function automatic logic parity_of(input logic [7:0] d, input par_mode_e m);
    case (m)
      PAR_ODD:  return ~^d;                          // Total ones odd
      PAR_EVEN: return ^d;
      PAR_ONE:  return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  // Host side pulses
  task automatic read_rhr();
    @(posedge clk);
    rhr_rd <= 1'b1;
    @(posedge clk);
    rhr_rd <= 1'b0;
  endtask

  task automatic clear_status();
    @(posedge clk);
    lsr_rd <= 1'b1;
    @(posedge clk);
    lsr_rd <= 1'b0;
  endtask

  // --------------------
  // Checks and waits
  // --------------------
  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (exp === act) else begin
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(negedge clk);                                // Outputs settled
      n++;
    end while (!data_ready && n < READY_MAX);
    if (!data_ready) abort_run("Timed out waiting for a received character");
  endtask

  task automatic wait_timeout(output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!timeout && n < TIMEOUT_TICKS + FRAME_CYC);
    if (!timeout) abort_run("Character timeout never fired with characters waiting");
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %-10s %s, %0d errors", name,
             (errors == errs_before) ? "passed" : "failed", errors - errs_before);
    errs_before = errors;
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [7:0] ch;
    int         n;
    seed   = 32'h962a;
    errors = 0;
    checks = 0;
    tests  = 0;
    errs_before = 0;
    rst_n    = 1'b0;
    tick     = 1'b1;                                 // Tick every clock
    rxd      = 1'b1;
    word_len = WLEN_8;
    par_en   = 1'b0;
    par_mode = PAR_ODD;
    trig_lvl = TRIG_4;
    rhr_rd   = 1'b0;
    lsr_rd   = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("reset flags", 8'h00,
              {1'b0, data_ready, overrun_err, par_err, frame_err, brk, trigger, timeout});
    end_test("reset");

    for (int i = 0; i < 8; i++) begin
      ch = $random(seed);
      send_frame(ch, 8, 1'b0, 1'b0, 1'b1);
      wait_ready();
      check_val("8n1 char", ch, rhr);
      check_val("8n1 flags", 8'h00, {4'h0, overrun_err, par_err, frame_err, brk});
      read_rhr();
    end
    end_test("8n1");

    @(posedge clk);
    par_en <= 1'b1;
    for (int m = 0; m < 4; m++) begin
      @(posedge clk);
      par_mode <= par_mode_e'(m);
      ch = $random(seed);
      send_frame(ch, 8, 1'b1, parity_of(ch, par_mode_e'(m)), 1'b1);
      wait_ready();
      check_val("parity char", ch, rhr);
      check_val("parity good", 8'h00, {7'h0, par_err});
      read_rhr();
      send_frame(ch, 8, 1'b1, ~parity_of(ch, par_mode_e'(m)), 1'b1);  // Flipped bit
      wait_ready();
      check_val("parity bad", 8'h01, {7'h0, par_err});
      read_rhr();
      @(negedge clk);
      check_val("parity sticky", 8'h01, {7'h0, par_err});
      clear_status();
      @(negedge clk);
      check_val("parity clear", 8'h00, {7'h0, par_err});
    end
    @(posedge clk);
    par_en <= 1'b0;
    end_test("parity");

    send_frame(8'h5a, 8, 1'b0, 1'b0, 1'b0);          // Stop bit low
    wait_ready();
    check_val("frame char", 8'h5a, rhr);
    check_val("frame flags", 8'h02, {6'h0, frame_err, brk});
    read_rhr();
    clear_status();
    send_frame(8'h00, 8, 1'b0, 1'b0, 1'b0);          // Whole frame low
    wait_ready();
    check_val("break flags", 8'h03, {6'h0, frame_err, brk});
    read_rhr();
    clear_status();
    @(negedge clk);
    check_val("break clear", 8'h00, {6'h0, frame_err, brk});
    end_test("framing");

    // Ones left in the upper shift register bits
    send_frame(8'hff, 8, 1'b0, 1'b0, 1'b1);
    wait_ready();
    check_val("5bit setup", 8'hff, rhr);
    read_rhr();
    @(posedge clk);
    word_len <= WLEN_5;
    for (int i = 0; i < 4; i++) begin
      ch = $random(seed);
      send_frame(ch, 5, 1'b0, 1'b0, 1'b1);
      wait_ready();
      check_val("5bit char", {3'b000, ch[4:0]}, rhr);  // Upper bits zero
      read_rhr();
    end
    @(posedge clk);
    word_len <= WLEN_8;
    end_test("5bit");

    // RHR and 16 FIFO slots fill up before the 18th
    for (int i = 0; i < 18; i++) begin
      exp_chars[i] = $random(seed);
      send_frame(exp_chars[i], 8, 1'b0, 1'b0, 1'b1);
    end
    @(negedge clk);
    check_val("overrun set", 8'h01, {7'h0, overrun_err});
    for (int i = 0; i < 17; i++) begin
      wait_ready();
      check_val("overrun char", exp_chars[i], rhr);
      read_rhr();
    end
    repeat (4) @(negedge clk);
    check_val("overrun drained", 8'h00, {7'h0, data_ready});
    clear_status();
    end_test("overrun");

    for (int i = 0; i < 3; i++) send_frame($random(seed), 8, 1'b0, 1'b0, 1'b1);
    @(negedge clk);
    check_val("trigger at 3", 8'h00, {7'h0, trigger});
    send_frame($random(seed), 8, 1'b0, 1'b0, 1'b1);
    @(negedge clk);
    check_val("trigger at 4", 8'h01, {7'h0, trigger});
    read_rhr();                                      // Restarts the idle timer
    wait_timeout(n);
    check_val("timeout delay", 8'h01, {7'h0, n >= TIMEOUT_TICKS});
    @(negedge clk);
    check_val("timeout pulse", 8'h00, {6'h0, timeout, trigger});  // 3 held now
    end_test("trigger");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: src.f
uart_cfg_pkg.sv
uart_rx_pkg.sv
uart_rx_sampler.sv
uart_rx_deframer.sv
uart_rx_fifo.sv
uart_rx_holding.sv
uart_rx.sv
tb_uart_rx.sv
